//--- bench/coreTb.sv
`timescale 1ns/10ps

module coreTb;

  logic                               clk;
  logic                               arstN;
  rvIsaPkg::word_t                    imemAddr;
  rvIsaPkg::word_t                    imemData;
  rvIsaPkg::word_t                    dmemAddr;
  rvIsaPkg::word_t                    dmemWData;
  logic                               dmemWe;
  rvIsaPkg::word_t                    dmemRData;
  logic                               retire;
  logic                               halted;
  logic [coreCtrlPkg::countWidth-1:0] cycleCount;
  logic [coreCtrlPkg::countWidth-1:0] instretCount;

  rvIsaPkg::word_t imem [256];
  rvIsaPkg::word_t dmem [1024];
  rvIsaPkg::word_t prog [$];     // program being built
  rvIsaPkg::word_t expAddr [$];  // expected stores, in order
  rvIsaPkg::word_t expData [$];
  rvIsaPkg::word_t gotAddr [$];  // stores seen on dmemWe
  rvIsaPkg::word_t gotData [$];
  int              errors = 0;
  int              passTests = 0;
  int              failTests = 0;
  int              cycles = 0;
  int              limit = 50;   // grows by 5 per loaded instruction
  int              retires = 0;  // retire pulses in the current run
  rvIsaPkg::word_t seed = 32'hf36d;

  rvCoreTop DUT (
    .clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
    .dmemAddr(dmemAddr), .dmemWData(dmemWData), .dmemWe(dmemWe), .dmemRData(dmemRData),
    .retire(retire), .halted(halted), .cycleCount(cycleCount), .instretCount(instretCount)
  );

  always #50 clk = ~clk;

  // both memories answer in the same cycle
  assign imemData  = imem[imemAddr[9:2]];
  assign dmemRData = dmem[dmemAddr[11:2]];

  // store strobe is stable mid-cycle
  always @(negedge clk) begin
    if (dmemWe) begin
      gotAddr.push_back(dmemAddr);
      gotData.push_back(dmemWData);
      dmem[dmemAddr[11:2]] = dmemWData;
    end
    if (retire)
      retires++; // one per cycle high
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic rvIsaPkg::word_t nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223; // lcg step
    return seed;
  endfunction

  // instruction encoders, one per format
  function automatic rvIsaPkg::word_t rFmt(logic [6:0] f7, logic [4:0] rd, logic [4:0] rs1,
                                           logic [4:0] rs2);
    return {f7, rs2, rs1, rvIsaPkg::f3Add, rd, rvIsaPkg::opReg};
  endfunction

  function automatic rvIsaPkg::word_t iFmt(rvIsaPkg::opcode_e op, logic [2:0] f3,
                                           logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rvIsaPkg::word_t sFmt(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, rvIsaPkg::f3Word, imm[4:0], rvIsaPkg::store};
  endfunction

  function automatic rvIsaPkg::word_t bFmt(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvIsaPkg::branch};
  endfunction

  function automatic rvIsaPkg::word_t uFmt(rvIsaPkg::opcode_e op, logic [4:0] rd,
                                           logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic rvIsaPkg::word_t jFmt(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvIsaPkg::jal};
  endfunction

  function automatic rvIsaPkg::word_t sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // branch rule from the isa
  function automatic bit branchTaken(logic [2:0] f3, rvIsaPkg::word_t a, rvIsaPkg::word_t b);
    case (f3)
      rvIsaPkg::f3Beq:  return a == b;
      rvIsaPkg::f3Bne:  return a != b;
      rvIsaPkg::f3Blt:  return $signed(a) < $signed(b);
      rvIsaPkg::f3Bge:  return $signed(a) >= $signed(b);
      rvIsaPkg::f3Bltu: return a < b;
      default:          return a >= b; // bgeu
    endcase
  endfunction

  task automatic storeWord(logic [4:0] rs2, rvIsaPkg::word_t addr, rvIsaPkg::word_t data);
    prog.push_back(sFmt(rs2, 5'd0, addr[11:0]));
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic checkWord(rvIsaPkg::word_t got, rvIsaPkg::word_t exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkCount(logic [coreCtrlPkg::countWidth-1:0] got,
                            logic [coreCtrlPkg::countWidth-1:0] exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // load, reset, wait for halt, then check stores and optionally the counters
  task automatic runProgram(string name, bit doCounts);
    int errBefore;
    int plainN;
    int memN;
    int waited;
    int n;
    errBefore = errors;
    plainN = 0;
    memN = 0;
    waited = 0;
    foreach (prog[i]) begin
      if (prog[i][6:0] == rvIsaPkg::load || prog[i][6:0] == rvIsaPkg::store)
        memN++;
      else if (prog[i][6:0] != rvIsaPkg::system)
        plainN++;
    end
    limit += 5 * prog.size();
    @(negedge clk);
    arstN = 1'b0;
    for (int i = 0; i < 256; i++)
      imem[i] = (i < prog.size()) ? prog[i] : rvIsaPkg::word_t'(i) << 7; // unknown op fill
    for (int i = 0; i < 1024; i++)
      dmem[i] = (rvIsaPkg::word_t'(i) * 32'h0001_0003) ^ 32'ha5a5_0000;
    gotAddr.delete();
    gotData.delete();
    retires = 0;
    repeat (2) @(negedge clk);
    arstN = 1'b1;
    while (!halted && waited < prog.size() * 5 + 10) begin
      @(negedge clk);
      waited++;
    end
    if (!halted) begin
      $display("%s: core never reached halt after %0d cycles", name, waited);
      errors++;
    end else begin
      repeat (2) @(negedge clk);
      if (!halted) begin
        $display("%s: halted dropped without a reset", name);
        errors++;
      end
      if (gotAddr.size() != expAddr.size()) begin
        $display("%s: expected %0d stores but saw %0d", name, expAddr.size(), gotAddr.size());
        errors++;
      end
      n = (gotAddr.size() < expAddr.size()) ? gotAddr.size() : expAddr.size();
      for (int i = 0; i < n; i++) begin
        checkWord(gotAddr[i], expAddr[i], $sformatf("%s store %0d addr", name, i));
        checkWord(gotData[i], expData[i], $sformatf("%s store %0d data", name, i));
      end
      if (doCounts) begin
        checkCount(retires, plainN + memN, {name, " retire pulses"}); // none for ebreak
        checkCount(instretCount, plainN + memN, {name, " instretCount"}); // ebreak not retired
        checkCount(cycleCount, 4 * plainN + 5 * memN + 3, {name, " cycleCount"});
      end
    end
    if (errors == errBefore) begin
      passTests++;
      $display("%s: pass, %0d stores", name, gotAddr.size());
    end else begin
      failTests++;
      $display("%s: FAIL, %0d errors", name, errors - errBefore);
    end
    prog.delete();
    expAddr.delete();
    expData.delete();
  endtask

  task automatic arithTest();
    rvIsaPkg::word_t a;
    rvIsaPkg::word_t b;
    a = 32'd1234;
    b = sext12(-12'sd77);
    prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, 5'd1, 5'd0, 12'd1234));
    prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, 5'd2, 5'd0, -12'sd77));
    prog.push_back(rFmt(rvIsaPkg::f7Base, 5'd3, 5'd1, 5'd2));  // add
    prog.push_back(rFmt(rvIsaPkg::f7Sub, 5'd4, 5'd2, 5'd1));   // sub
    prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Sltiu, 5'd5, 5'd2, 12'd5));
    prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Sltiu, 5'd6, 5'd1, 12'd2000));
    storeWord(5'd3, 32'h100, a + b);
    storeWord(5'd4, 32'h104, b - a);
    storeWord(5'd5, 32'h108, (b < 32'd5) ? 32'd1 : 32'd0);    // huge unsigned, so 0
    storeWord(5'd6, 32'h10c, (a < 32'd2000) ? 32'd1 : 32'd0);
    prog.push_back(32'h0010_0073);
    runProgram("arith", 1'b1);
  endtask

  task automatic branchTest();
    rvIsaPkg::word_t vals [4];
    logic [2:0]      f3s [6];
    logic [4:0]      pa [3];
    logic [4:0]      pb [3];
    int              k;
    vals = '{32'd0, 32'h8000_0000, 32'd1, 32'd1}; // signed min, unsigned large
    f3s = '{rvIsaPkg::f3Beq, rvIsaPkg::f3Bne, rvIsaPkg::f3Blt, rvIsaPkg::f3Bge,
            rvIsaPkg::f3Bltu, rvIsaPkg::f3Bgeu};
    pa = '{5'd1, 5'd2, 5'd2};
    pb = '{5'd2, 5'd1, 5'd3};
    k = 0;
    prog.push_back(uFmt(rvIsaPkg::lui, 5'd1, 20'h80000));
    prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, 5'd2, 5'd0, 12'd1));
    prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, 5'd3, 5'd0, 12'd1));
    foreach (f3s[f]) begin
      foreach (pa[p]) begin
        prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, 5'd10, 5'd0, 12'd2));
        prog.push_back(bFmt(f3s[f], pa[p], pb[p], 13'd8)); // taken skips the next one
        prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, 5'd10, 5'd0, 12'd1));
        storeWord(5'd10, 32'h200 + 4 * k,
                  branchTaken(f3s[f], vals[pa[p]], vals[pb[p]]) ? 32'd2 : 32'd1);
        k++;
      end
    end
    prog.push_back(32'h0010_0073);
    runProgram("branch", 1'b0);
  endtask

  task automatic loadStoreTest();
    rvIsaPkg::word_t v;
    v = (32'hcafe1 << 12) + 32'h23b;
    prog.push_back(uFmt(rvIsaPkg::lui, 5'd1, 20'hcafe1));
    prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, 5'd1, 5'd1, 12'h23b));
    storeWord(5'd1, 32'h300, v);
    prog.push_back(iFmt(rvIsaPkg::load, rvIsaPkg::f3Word, 5'd2, 5'd0, 12'h300));
    storeWord(5'd2, 32'h304, v); // loaded copy
    prog.push_back(32'h0010_0073);
    runProgram("loadStore", 1'b1);
  endtask

  task automatic jumpTest();
    rvIsaPkg::word_t jalrTarget;
    jalrTarget = 32'd37 & ~32'd1;
    prog.push_back(uFmt(rvIsaPkg::lui, 5'd1, 20'h12345));          // pc 0
    prog.push_back(uFmt(rvIsaPkg::auipc, 5'd2, 20'h00001));        // pc 4
    prog.push_back(jFmt(5'd3, 21'd8));                             // pc 8 to 16
    prog.push_back(sFmt(5'd1, 5'd0, 12'h4fc));                     // skipped
    prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, 5'd4, 5'd0, 12'd37));
    prog.push_back(iFmt(rvIsaPkg::jalr, rvIsaPkg::f3Jalr, 5'd5, 5'd4, 12'd0)); // pc 20
    while (prog.size() * 4 < jalrTarget)
      prog.push_back(sFmt(5'd1, 5'd0, 12'h4f0)); // never reached
    prog.push_back(uFmt(rvIsaPkg::auipc, 5'd6, 20'h00000)); // pc as seen at the jalr target
    storeWord(5'd1, 32'h400, 32'h1234_5000);
    storeWord(5'd2, 32'h404, 32'd4 + 32'h1000);
    storeWord(5'd3, 32'h408, 32'd8 + 32'd4);    // jal link
    storeWord(5'd5, 32'h40c, 32'd20 + 32'd4);   // jalr link
    storeWord(5'd6, 32'h410, jalrTarget);       // low bit gone
    prog.push_back(32'h0010_0073);
    runProgram("jump", 1'b0);
  endtask

  task automatic countTest();
    prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, 5'd1, 5'd0, 12'd5));
    prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, 5'd2, 5'd1, 12'd3));
    storeWord(5'd2, 32'h500, 32'd8);
    prog.push_back(iFmt(rvIsaPkg::load, rvIsaPkg::f3Word, 5'd3, 5'd0, 12'h500));
    prog.push_back(rFmt(rvIsaPkg::f7Base, 5'd4, 5'd3, 5'd1));
    storeWord(5'd4, 32'h504, 32'd13);
    prog.push_back(32'h0010_0073);
    runProgram("counts", 1'b1);
  endtask

  task automatic randomTest();
    rvIsaPkg::word_t model [32];
    rvIsaPkg::word_t r;
    int              rd;
    int              rs1;
    int              rs2;
    foreach (model[i])
      model[i] = '0;
    for (int i = 1; i <= 2; i++) begin
      r = nextRand();
      model[i] = sext12(r[11:0]);
      prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, i, 5'd0, r[11:0]));
    end
    for (int k = 0; k < 10; k++) begin
      r = nextRand();
      rd = 3 + k;
      rs1 = 1 + r[7:0] % (rd - 1);
      rs2 = 1 + r[15:8] % (rd - 1);
      case (r[17:16] % 3)
        0: begin
          model[rd] = model[rs1] + model[rs2];
          prog.push_back(rFmt(rvIsaPkg::f7Base, rd, rs1, rs2));
        end
        1: begin
          model[rd] = model[rs1] - model[rs2];
          prog.push_back(rFmt(rvIsaPkg::f7Sub, rd, rs1, rs2));
        end
        default: begin
          model[rd] = model[rs1] + sext12(r[31:20]);
          prog.push_back(iFmt(rvIsaPkg::opImm, rvIsaPkg::f3Add, rd, rs1, r[31:20]));
        end
      endcase
      storeWord(rd, 32'h600 + 4 * k, model[rd]);
    end
    prog.push_back(32'h0010_0073);
    runProgram("random", 1'b1);
  endtask

  initial begin
    clk = 1'b0;
    arstN = 1'b0;
    for (int i = 0; i < 256; i++)
      imem[i] = rvIsaPkg::word_t'(i) << 7;
    for (int i = 0; i < 1024; i++)
      dmem[i] = (rvIsaPkg::word_t'(i) * 32'h0001_0003) ^ 32'ha5a5_0000;
    arithTest();
    branchTest();
    loadStoreTest();
    jumpTest();
    countTest();
    randomTest();
    $display("tests passed %0d, failed %0d, errors %0d", passTests, failTests, errors);
    if (failTests == 0 && errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- src/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
  input  rvIsaPkg::word_t     a,
  input  rvIsaPkg::word_t     b,
  input  coreCtrlPkg::aluOp_e aluOp,
  input  logic                brUn,
  output rvIsaPkg::word_t     result,
  output logic                brEq,
  output logic                brLt
);

  rvIsaPkg::word_t sum;

  assign sum = a + b; // shared by add and jalr

  always_comb begin
    case (aluOp)
      coreCtrlPkg::add:         result = sum;
      coreCtrlPkg::passB:       result = b;
      coreCtrlPkg::addClearLsb: result = {sum[31:1], 1'b0};
      coreCtrlPkg::sub:         result = a - b;
      coreCtrlPkg::setLtu:      result = {31'd0, a < b};
      default:                  result = sum;
    endcase
  end

  // comparator side
  assign brEq = (a == b);
  assign brLt = brUn ? (a < b) : ($signed(a) < $signed(b));

endmodule

//--- src/coreCtrlPkg.sv
package coreCtrlPkg;

  // alu operations
  typedef enum logic [2:0] {
    add         = 3'd0,
    passB       = 3'd1, // lui
    addClearLsb = 3'd2, // jalr target
    sub         = 3'd3,
    setLtu      = 3'd4  // sltiu
  } aluOp_e;

  // write-back source, memData is the all-zero default
  typedef enum logic [1:0] {
    memData   = 2'b00,
    aluResult = 2'b01,
    pcPlus4   = 2'b10
  } wbSel_e;

  // one-hot style so lookups can be ored together
  typedef enum logic [1:0] {
    idle  = 2'b00,
    read  = 2'b10,
    write = 2'b01
  } memCmd_e;

  typedef enum logic [2:0] {
    fetch,
    decode,
    execute,
    memory,    // lw / sw only
    writeBack,
    halt       // sticky until reset
  } state_e;

  localparam rvIsaPkg::word_t resetPc = 32'h0000_0000;
  localparam int countWidth = 32;

endpackage

//--- src/coreFsm.sv
`timescale 1ns/10ps

module coreFsm (
  input  logic                clk,
  input  logic                arstN,
  ctrlIf.seq                  ctrl,
  output logic                irLoad,
  output logic                opLoad,
  output logic                exLoad,
  output logic                memLoad,
  output logic                dmemWe,
  output logic                retire,
  output logic                halted,
  output coreCtrlPkg::state_e state
);

  coreCtrlPkg::state_e nextState;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      state <= coreCtrlPkg::fetch;
    else
      state <= nextState;
  end

  always_comb begin
    nextState = state;
    case (state)
      coreCtrlPkg::fetch:     nextState = coreCtrlPkg::decode;
      coreCtrlPkg::decode:    nextState = coreCtrlPkg::execute;
      coreCtrlPkg::execute: begin
        if (ctrl.ebreak)
          nextState = coreCtrlPkg::halt; // no write-back, no retire
        else if (ctrl.memCmd != coreCtrlPkg::idle)
          nextState = coreCtrlPkg::memory;
        else
          nextState = coreCtrlPkg::writeBack;
      end
      coreCtrlPkg::memory:    nextState = coreCtrlPkg::writeBack;
      coreCtrlPkg::writeBack: nextState = coreCtrlPkg::fetch;
      default:                nextState = coreCtrlPkg::halt;
    endcase
  end

  // phase enables straight from state
  assign irLoad  = (state == coreCtrlPkg::fetch);
  assign opLoad  = (state == coreCtrlPkg::decode);
  assign exLoad  = (state == coreCtrlPkg::execute);
  assign memLoad = (state == coreCtrlPkg::memory) && (ctrl.memCmd == coreCtrlPkg::read);
  assign dmemWe  = (state == coreCtrlPkg::memory) && (ctrl.memCmd == coreCtrlPkg::write);
  assign retire  = (state == coreCtrlPkg::writeBack);
  assign halted  = (state == coreCtrlPkg::halt);

  weOnePulse: assert property (@(posedge clk) disable iff (!arstN) dmemWe |=> !dmemWe)
    else $error("coreFsm store strobe longer than one cycle");
  retireOnePulse: assert property (@(posedge clk) disable iff (!arstN) retire |=> !retire)
    else $error("coreFsm retire longer than one cycle");
  haltSticky: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
    else $error("coreFsm left halt without reset");

endmodule

//--- src/ctrlIf.sv
`timescale 1ns/10ps

interface ctrlIf;
  logic                 regWrite;
  coreCtrlPkg::memCmd_e memCmd;
  logic                 pcSel;    // jump or taken branch
  logic                 aluASel;  // high picks pc over rs1
  logic                 aluBSel;  // high picks imm over rs2
  coreCtrlPkg::wbSel_e  wbSel;
  coreCtrlPkg::aluOp_e  aluOp;
  logic                 brUn;     // unsigned compare for bltu / bgeu
  logic                 ebreak;
  rvIsaPkg::instType_e  instType;

  modport decode (output regWrite, memCmd, pcSel, aluASel, aluBSel, wbSel, aluOp,
                  brUn, ebreak, instType);
  // sequencer only cares about memory phase and halt
  modport seq (input memCmd, ebreak);
  modport path (input regWrite, pcSel, aluASel, aluBSel, wbSel, aluOp, brUn, instType);

endinterface

//--- src/immGen.sv
`timescale 1ns/10ps

module immGen (
  input  rvIsaPkg::word_t     inst,
  input  rvIsaPkg::instType_e instType,
  output rvIsaPkg::word_t     imm
);

  // sign bit is always inst[31]
  always_comb begin
    case (instType)
      rvIsaPkg::typeI: imm = {{20{inst[31]}}, inst[31:20]};
      rvIsaPkg::typeS: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      rvIsaPkg::typeB: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                              inst[11:8], 1'b0}; // halfword offset
      rvIsaPkg::typeU: imm = {inst[31:12], 12'b0};
      rvIsaPkg::typeJ: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                              inst[30:21], 1'b0};
      default:         imm = '0; // R format
    endcase
  end

endmodule

//--- src/instDecoder.sv
`timescale 1ns/10ps

module instDecoder (
  input  rvIsaPkg::word_t inst,
  input  logic            brEq,
  input  logic            brLt,
  ctrlIf.decode           ctrl
);

  typedef struct packed {
    logic                 regWrite;
    coreCtrlPkg::memCmd_e memCmd;
    logic                 ebreak;
    logic                 pcSel;   // jumps, branches folded in later
    logic                 aluASel;
    logic                 aluBSel;
    coreCtrlPkg::wbSel_e  wbSel;
    coreCtrlPkg::aluOp_e  aluOp;
  } ctrlWord_t;

  rvIsaPkg::opcode_e opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  ctrlWord_t         opWord;  // keyed on opcode
  ctrlWord_t         f3Word;  // keyed on opcode + funct3
  ctrlWord_t         f7Word;  // keyed on opcode + funct3 + funct7
  ctrlWord_t         word;
  logic              brTaken;

  assign opcode = rvIsaPkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    opWord = '0;
    case (opcode)
      rvIsaPkg::auipc: opWord = '{1'b1, coreCtrlPkg::idle, 1'b0, 1'b0, 1'b1, 1'b1,
                                  coreCtrlPkg::aluResult, coreCtrlPkg::add};
      rvIsaPkg::lui:   opWord = '{1'b1, coreCtrlPkg::idle, 1'b0, 1'b0, 1'b0, 1'b1,
                                  coreCtrlPkg::aluResult, coreCtrlPkg::passB};
      rvIsaPkg::jal:   opWord = '{1'b1, coreCtrlPkg::idle, 1'b0, 1'b1, 1'b1, 1'b1,
                                  coreCtrlPkg::pcPlus4, coreCtrlPkg::add}; // pc + imm
      default:         opWord = '0;
    endcase
  end

  always_comb begin
    f3Word = '0;
    case ({opcode, funct3})
      {rvIsaPkg::opImm, rvIsaPkg::f3Add}:
        f3Word = '{1'b1, coreCtrlPkg::idle, 1'b0, 1'b0, 1'b0, 1'b1,
                   coreCtrlPkg::aluResult, coreCtrlPkg::add};
      {rvIsaPkg::opImm, rvIsaPkg::f3Sltiu}:
        f3Word = '{1'b1, coreCtrlPkg::idle, 1'b0, 1'b0, 1'b0, 1'b1,
                   coreCtrlPkg::aluResult, coreCtrlPkg::setLtu};
      {rvIsaPkg::jalr, rvIsaPkg::f3Jalr}: // rs1 + imm, lsb dropped
        f3Word = '{1'b1, coreCtrlPkg::idle, 1'b0, 1'b1, 1'b0, 1'b1,
                   coreCtrlPkg::pcPlus4, coreCtrlPkg::addClearLsb};
      {rvIsaPkg::load, rvIsaPkg::f3Word}:
        f3Word = '{1'b1, coreCtrlPkg::read, 1'b0, 1'b0, 1'b0, 1'b1,
                   coreCtrlPkg::memData, coreCtrlPkg::add};
      {rvIsaPkg::store, rvIsaPkg::f3Word}:
        f3Word = '{1'b0, coreCtrlPkg::write, 1'b0, 1'b0, 1'b0, 1'b1,
                   coreCtrlPkg::memData, coreCtrlPkg::add};
      {rvIsaPkg::system, rvIsaPkg::f3Ebreak}:
        f3Word = '{1'b0, coreCtrlPkg::idle, 1'b1, 1'b0, 1'b0, 1'b0,
                   coreCtrlPkg::memData, coreCtrlPkg::add};
      {rvIsaPkg::branch, rvIsaPkg::f3Beq}, {rvIsaPkg::branch, rvIsaPkg::f3Bne},
      {rvIsaPkg::branch, rvIsaPkg::f3Blt}, {rvIsaPkg::branch, rvIsaPkg::f3Bge},
      {rvIsaPkg::branch, rvIsaPkg::f3Bltu}, {rvIsaPkg::branch, rvIsaPkg::f3Bgeu}:
        f3Word = '{1'b0, coreCtrlPkg::idle, 1'b0, 1'b0, 1'b1, 1'b1,
                   coreCtrlPkg::memData, coreCtrlPkg::add}; // target pc + imm
      default: f3Word = '0;
    endcase
  end

  always_comb begin
    f7Word = '0;
    case ({opcode, funct3, funct7})
      {rvIsaPkg::opReg, rvIsaPkg::f3Add, rvIsaPkg::f7Base}:
        f7Word = '{1'b1, coreCtrlPkg::idle, 1'b0, 1'b0, 1'b0, 1'b0,
                   coreCtrlPkg::aluResult, coreCtrlPkg::add};
      {rvIsaPkg::opReg, rvIsaPkg::f3Add, rvIsaPkg::f7Sub}:
        f7Word = '{1'b1, coreCtrlPkg::idle, 1'b0, 1'b0, 1'b0, 1'b0,
                   coreCtrlPkg::aluResult, coreCtrlPkg::sub};
      default: f7Word = '0;
    endcase
  end

  // branch condition from the comparator flags
  always_comb begin
    brTaken = 1'b0;
    case ({opcode, funct3})
      {rvIsaPkg::branch, rvIsaPkg::f3Beq}:  brTaken = brEq;
      {rvIsaPkg::branch, rvIsaPkg::f3Bne}:  brTaken = !brEq;
      {rvIsaPkg::branch, rvIsaPkg::f3Blt},
      {rvIsaPkg::branch, rvIsaPkg::f3Bltu}: brTaken = brLt; // brUn sets the compare
      {rvIsaPkg::branch, rvIsaPkg::f3Bge},
      {rvIsaPkg::branch, rvIsaPkg::f3Bgeu}: brTaken = !brLt;
      default:                              brTaken = 1'b0;
    endcase
  end

  // tables never overlap, so or-ing them is a plain merge
  assign word = ctrlWord_t'(opWord | f3Word | f7Word);

  assign ctrl.regWrite = word.regWrite;
  assign ctrl.memCmd   = word.memCmd;
  assign ctrl.ebreak   = word.ebreak;
  assign ctrl.pcSel    = word.pcSel | brTaken;
  assign ctrl.aluASel  = word.aluASel;
  assign ctrl.aluBSel  = word.aluBSel;
  assign ctrl.wbSel    = word.wbSel;
  assign ctrl.aluOp    = word.aluOp;
  assign ctrl.brUn     = (opcode == rvIsaPkg::branch) &&
                         (funct3 == rvIsaPkg::f3Bltu || funct3 == rvIsaPkg::f3Bgeu);

  always_comb begin
    case (opcode)
      rvIsaPkg::lui, rvIsaPkg::auipc:                  ctrl.instType = rvIsaPkg::typeU;
      rvIsaPkg::jal:                                   ctrl.instType = rvIsaPkg::typeJ;
      rvIsaPkg::jalr, rvIsaPkg::load, rvIsaPkg::opImm: ctrl.instType = rvIsaPkg::typeI;
      rvIsaPkg::store:                                 ctrl.instType = rvIsaPkg::typeS;
      rvIsaPkg::branch:                                ctrl.instType = rvIsaPkg::typeB;
      default:                                         ctrl.instType = rvIsaPkg::typeR;
    endcase
  end

  // merged lookups must not mix read with write or ebreak with a write-back
  always_comb begin
    assert final (word.memCmd != 2'b11 && !(word.ebreak && word.regWrite))
      else $error("instDecoder overlapping lookup entries for %h", inst);
  end

endmodule

//--- src/perfCounter.sv
`timescale 1ns/10ps

module perfCounter (
  input  logic                                clk,
  input  logic                                arstN,
  input  logic                                halted,
  input  logic                                retire,
  output logic [coreCtrlPkg::countWidth-1:0]  cycleCount,
  output logic [coreCtrlPkg::countWidth-1:0]  instretCount
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cycleCount   <= '0;
      instretCount <= '0;
    end else begin
      if (!halted)
        cycleCount <= cycleCount + 1'b1; // frozen once halted
      if (retire)
        instretCount <= instretCount + 1'b1;
    end
  end

endmodule

//--- src/regFile.sv
`timescale 1ns/10ps

module regFile (
  input  logic            clk,
  input  logic            arstN,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  rvIsaPkg::word_t wrData,
  input  logic            wrEn,
  output rvIsaPkg::word_t rd1,
  output rvIsaPkg::word_t rd2
);

  rvIsaPkg::word_t regs [32];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wrEn && rd != 5'd0) begin // x0 stays zero
      regs[rd] <= wrData;
    end
  end

  // combinational reads
  assign rd1 = regs[rs1];
  assign rd2 = regs[rs2];

  x0Zero: assert property (@(posedge clk) disable iff (!arstN) (rs1 == 5'd0) |-> rd1 == '0)
    else $error("regFile x0 read back nonzero");

endmodule

//--- src/rvCoreTop.sv
`timescale 1ns/10ps

module rvCoreTop (
  input  logic                               clk,
  input  logic                               arstN,
  output rvIsaPkg::word_t                    imemAddr,
  input  rvIsaPkg::word_t                    imemData,
  output rvIsaPkg::word_t                    dmemAddr,
  output rvIsaPkg::word_t                    dmemWData,
  output logic                               dmemWe,
  input  rvIsaPkg::word_t                    dmemRData,
  output logic                               retire,
  output logic                               halted,
  output logic [coreCtrlPkg::countWidth-1:0] cycleCount,
  output logic [coreCtrlPkg::countWidth-1:0] instretCount
);

  rvIsaPkg::word_t     pc;
  rvIsaPkg::word_t     ir;
  rvIsaPkg::word_t     rs1Val;  // operand regs, loaded in decode
  rvIsaPkg::word_t     rs2Val;
  rvIsaPkg::word_t     immVal;
  rvIsaPkg::word_t     aluReg;  // loaded in execute
  rvIsaPkg::word_t     loadReg;
  logic                takeReg; // registered pcSel
  rvIsaPkg::word_t     rd1;
  rvIsaPkg::word_t     rd2;
  rvIsaPkg::word_t     imm;
  rvIsaPkg::word_t     aluA;
  rvIsaPkg::word_t     aluB;
  rvIsaPkg::word_t     aluOut;
  rvIsaPkg::word_t     wbData;
  rvIsaPkg::word_t     pcPlus4;
  logic                brEq;
  logic                brLt;
  logic                irLoad;
  logic                opLoad;
  logic                exLoad;
  logic                memLoad;
  logic                rfWe;
  coreCtrlPkg::state_e fsmState;

  ctrlIf ctrl ();

  instDecoder uDecoder (.inst(ir), .brEq(brEq), .brLt(brLt), .ctrl(ctrl));
  immGen uImm (.inst(ir), .instType(ctrl.instType), .imm(imm));

  // main alu, comparator flags unused here
  aluUnit uAlu (.a(aluA), .b(aluB), .aluOp(ctrl.aluOp), .brUn(ctrl.brUn),
                .result(aluOut), .brEq(), .brLt());
  // branch comparator on rs1 / rs2 while the alu forms the target
  aluUnit uCmp (.a(rs1Val), .b(rs2Val), .aluOp(ctrl.aluOp), .brUn(ctrl.brUn),
                .result(), .brEq(brEq), .brLt(brLt));

  regFile uRegs (.clk(clk), .arstN(arstN), .rs1(ir[19:15]), .rs2(ir[24:20]), .rd(ir[11:7]),
                 .wrData(wbData), .wrEn(rfWe), .rd1(rd1), .rd2(rd2));

  coreFsm uFsm (.clk(clk), .arstN(arstN), .ctrl(ctrl), .irLoad(irLoad), .opLoad(opLoad),
                .exLoad(exLoad), .memLoad(memLoad), .dmemWe(dmemWe), .retire(retire),
                .halted(halted), .state(fsmState));

  perfCounter uPerf (.clk(clk), .arstN(arstN), .halted(halted), .retire(retire),
                     .cycleCount(cycleCount), .instretCount(instretCount));

  assign pcPlus4 = pc + 32'd4;
  assign aluA    = ctrl.aluASel ? pc : rs1Val;
  assign aluB    = ctrl.aluBSel ? immVal : rs2Val;
  assign rfWe    = (fsmState == coreCtrlPkg::writeBack) && ctrl.regWrite;

  always_comb begin
    case (ctrl.wbSel)
      coreCtrlPkg::memData:   wbData = loadReg;
      coreCtrlPkg::aluResult: wbData = aluReg;
      coreCtrlPkg::pcPlus4:   wbData = pcPlus4; // link value
      default:                wbData = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc      <= coreCtrlPkg::resetPc;
      ir      <= '0; // decodes as unknown, all controls off
      takeReg <= 1'b0;
    end else begin
      if (irLoad)
        ir <= imemData;
      if (exLoad)
        takeReg <= ctrl.pcSel;
      if (retire)
        pc <= takeReg ? aluReg : pcPlus4; // jump / taken branch target from alu
    end
  end

  always_ff @(posedge clk) begin
    if (opLoad) begin
      rs1Val <= rd1;
      rs2Val <= rd2;
      immVal <= imm;
    end
    if (exLoad)
      aluReg <= aluOut;
    if (memLoad)
      loadReg <= dmemRData;
  end

  assign imemAddr  = pc;
  assign dmemAddr  = aluReg; // word access only
  assign dmemWData = rs2Val;

endmodule

//--- src/rvIsaPkg.sv
package rvIsaPkg;

  typedef logic [31:0] word_t; // data and address word

  // major opcodes of the subset
  typedef enum logic [6:0] {
    opImm  = 7'b0010011, // addi, sltiu
    opReg  = 7'b0110011, // add, sub
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    jal    = 7'b1101111,
    jalr   = 7'b1100111,
    load   = 7'b0000011,
    store  = 7'b0100011,
    branch = 7'b1100011,
    system = 7'b1110011  // ebreak only
  } opcode_e;

  // immediate layout of each format
  typedef enum logic [2:0] {
    typeR, // no immediate
    typeI,
    typeS,
    typeB,
    typeU,
    typeJ
  } instType_e;

  localparam logic [2:0] f3Add    = 3'b000; // addi, add and sub
  localparam logic [2:0] f3Sltiu  = 3'b011;
  localparam logic [2:0] f3Word   = 3'b010; // lw / sw
  localparam logic [2:0] f3Jalr   = 3'b000;
  localparam logic [2:0] f3Ebreak = 3'b000;
  localparam logic [2:0] f3Beq    = 3'b000;
  localparam logic [2:0] f3Bne    = 3'b001;
  localparam logic [2:0] f3Blt    = 3'b100;
  localparam logic [2:0] f3Bge    = 3'b101;
  localparam logic [2:0] f3Bltu   = 3'b110;
  localparam logic [2:0] f3Bgeu   = 3'b111;
  localparam logic [6:0] f7Base   = 7'b0000000;
  localparam logic [6:0] f7Sub    = 7'b0100000; // sub when opReg

endpackage

//--- verilog.f
src/rvIsaPkg.sv
src/coreCtrlPkg.sv
src/ctrlIf.sv
src/instDecoder.sv
src/immGen.sv
src/aluUnit.sv
src/regFile.sv
src/coreFsm.sv
src/perfCounter.sv
src/rvCoreTop.sv
bench/coreTb.sv
